//--- async_fifo/async_fifo.sv
`timescale 1ns/1ps

module async_fifo #(
  parameter int  FIFO_DEPTH  = cdc_fifo_pkg::DEFAULT_DEPTH,
  parameter int  FIFO_AFULL  = cdc_fifo_pkg::DEFAULT_AFULL,
  parameter int  FIFO_AEMPTY = cdc_fifo_pkg::DEFAULT_AEMPTY,
  localparam int ADDR_WIDTH  = $clog2(FIFO_DEPTH)
) (
  input  logic                     wr_clk,
  input  logic                     rst_n,
  input  logic                     wr_en,
  input  cdc_fifo_pkg::fifo_word_t wr_data,
  output cdc_fifo_pkg::fifo_flag_t wr_flags,
  input  logic                     rd_clk,
  input  logic                     rd_en,
  output cdc_fifo_pkg::fifo_word_t rd_data,
  output logic                     rd_valid,
  output cdc_fifo_pkg::fifo_flag_t rd_flags
);

  logic                  rd_rst_n;      // Reset as seen in the read domain
  logic                  ram_we;
  logic                  ram_re;
  logic [ADDR_WIDTH-1:0] ram_waddr;
  logic [ADDR_WIDTH-1:0] ram_raddr;
  logic [ADDR_WIDTH:0]   wr_ptr_gray;   // Crosses to rd_clk
  logic [ADDR_WIDTH:0]   rd_ptr_gray;   // Crosses to wr_clk

  fifo_wr_ctrl #(
    .FIFO_DEPTH (FIFO_DEPTH),
    .FIFO_AFULL (FIFO_AFULL)
  ) i_wr_ctrl (
    .wr_clk      (wr_clk),
    .rst_n       (rst_n),
    .wr_en       (wr_en),
    .we          (ram_we),
    .waddr       (ram_waddr),
    .wr_ptr_gray (wr_ptr_gray),
    .rd_ptr_gray (rd_ptr_gray),
    .wr_flags    (wr_flags)
  );

  fifo_rd_ctrl #(
    .FIFO_DEPTH  (FIFO_DEPTH),
    .FIFO_AEMPTY (FIFO_AEMPTY)
  ) i_rd_ctrl (
    .rd_clk      (rd_clk),
    .rst_n       (rst_n),
    .rd_rst_n    (rd_rst_n),
    .rd_en       (rd_en),
    .re          (ram_re),
    .raddr       (ram_raddr),
    .rd_ptr_gray (rd_ptr_gray),
    .wr_ptr_gray (wr_ptr_gray),
    .rd_flags    (rd_flags)
  );

  fifo_dual_port_ram #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) i_ram (
    .wr_clk   (wr_clk),
    .we       (ram_we),
    .waddr    (ram_waddr),
    .wdata    (wr_data),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .re       (ram_re),
    .raddr    (ram_raddr),
    .rdata    (rd_data),
    .rvalid   (rd_valid)
  );

endmodule

//--- async_fifo/fifo_dual_port_ram.sv
`timescale 1ns/1ps

module fifo_dual_port_ram #(
  parameter int  FIFO_DEPTH = cdc_fifo_pkg::DEFAULT_DEPTH,
  localparam int ADDR_WIDTH = $clog2(FIFO_DEPTH)
) (
  input  logic                     wr_clk,
  input  logic                     we,
  input  logic [ADDR_WIDTH-1:0]    waddr,
  input  cdc_fifo_pkg::fifo_word_t wdata,
  input  logic                     rd_clk,
  input  logic                     rd_rst_n,
  input  logic                     re,
  input  logic [ADDR_WIDTH-1:0]    raddr,
  output cdc_fifo_pkg::fifo_word_t rdata,
  output logic                     rvalid
);
  import cdc_fifo_pkg::*;

  fifo_word_t mem [0:FIFO_DEPTH-1];

  always_ff @(posedge wr_clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // Read port, output held between reads
  always_ff @(posedge rd_clk) begin
    if (re) begin
      rdata <= mem[raddr];
    end
  end

  always_ff @(posedge rd_clk) begin
    if (!rd_rst_n) begin
      rvalid <= 1'b0;
    end else begin
      rvalid <= re;  // One cycle after the read
    end
  end

  a_raddr_known: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
    re |-> !$isunknown(raddr))
    else $error("read enable with unknown read address");

endmodule

//--- async_fifo/fifo_rd_ctrl.sv
`timescale 1ns/1ps

module fifo_rd_ctrl #(
  parameter int  FIFO_DEPTH  = cdc_fifo_pkg::DEFAULT_DEPTH,
  parameter int  FIFO_AEMPTY = cdc_fifo_pkg::DEFAULT_AEMPTY,
  localparam int ADDR_WIDTH  = $clog2(FIFO_DEPTH)
) (
  input  logic                     rd_clk,
  input  logic                     rst_n,
  output logic                     rd_rst_n,
  input  logic                     rd_en,
  output logic                     re,
  output logic [ADDR_WIDTH-1:0]    raddr,
  output logic [ADDR_WIDTH:0]      rd_ptr_gray,
  input  logic [ADDR_WIDTH:0]      wr_ptr_gray,
  output cdc_fifo_pkg::fifo_flag_t rd_flags
);
  import cdc_fifo_pkg::*;

  localparam logic [ADDR_WIDTH:0] AEMPTY_LVL = (ADDR_WIDTH+1)'(FIFO_AEMPTY);

  logic [1:0]          rst_sync;
  logic [ADDR_WIDTH:0] rd_ptr_bin;
  logic [ADDR_WIDTH:0] rd_ptr_next;
  logic [ADDR_WIDTH:0] wr_gray_s1;
  logic [ADDR_WIDTH:0] wr_gray_s2;
  logic [ADDR_WIDTH:0] wr_ptr_sync;   // Binary write pointer, read domain
  logic [ADDR_WIDTH:0] rd_used_next;
  fifo_flag_t          flags_next;

  // Reset enters the read domain through two flops
  always_ff @(posedge rd_clk) begin
    rst_sync <= {rst_sync[0], rst_n};
  end

  assign rd_rst_n = rst_sync[1];

  assign re          = rd_en && !rd_flags.level;  // No read from an empty FIFO
  assign raddr       = rd_ptr_bin[ADDR_WIDTH-1:0];
  assign rd_ptr_next = rd_ptr_bin + {{ADDR_WIDTH{1'b0}}, re};

  always_ff @(posedge rd_clk) begin
    if (!rd_rst_n) begin
      rd_ptr_bin  <= '0;
      rd_ptr_gray <= '0;
    end else begin
      rd_ptr_bin  <= rd_ptr_next;
      rd_ptr_gray <= rd_ptr_next ^ (rd_ptr_next >> 1);
    end
  end

  always_ff @(posedge rd_clk) begin
    if (!rd_rst_n) begin
      wr_gray_s1 <= '0;
      wr_gray_s2 <= '0;
    end else begin
      wr_gray_s1 <= wr_ptr_gray;
      wr_gray_s2 <= wr_gray_s1;
    end
  end

  always_comb begin
    for (int i = 0; i <= ADDR_WIDTH; i++) begin
      wr_ptr_sync[i] = ^(wr_gray_s2 >> i);
    end
  end

  // Lagging write pointer makes this an underestimate
  assign rd_used_next = wr_ptr_sync - rd_ptr_next;

  always_comb begin
    flags_next.level  = (rd_ptr_next == wr_ptr_sync);
    flags_next.almost = (rd_used_next <= AEMPTY_LVL);
  end

  always_ff @(posedge rd_clk) begin
    if (!rd_rst_n) begin
      rd_flags <= '{level: 1'b1, almost: 1'b1};
    end else begin
      rd_flags <= flags_next;
    end
  end

  // Nothing is read past the synchronized write pointer
  a_no_underrun: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
    re |-> (wr_ptr_sync != rd_ptr_bin))
    else $error("read accepted while the FIFO was empty");

  a_rd_gray_step: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
    $countones(rd_ptr_gray ^ $past(rd_ptr_gray)) <= 1)
    else $error("read Gray pointer changed more than one bit");

endmodule

//--- async_fifo/fifo_wr_ctrl.sv
`timescale 1ns/1ps

module fifo_wr_ctrl #(
  parameter int  FIFO_DEPTH = cdc_fifo_pkg::DEFAULT_DEPTH,
  parameter int  FIFO_AFULL = cdc_fifo_pkg::DEFAULT_AFULL,
  localparam int ADDR_WIDTH = $clog2(FIFO_DEPTH)
) (
  input  logic                     wr_clk,
  input  logic                     rst_n,
  input  logic                     wr_en,
  output logic                     we,
  output logic [ADDR_WIDTH-1:0]    waddr,
  output logic [ADDR_WIDTH:0]      wr_ptr_gray,
  input  logic [ADDR_WIDTH:0]      rd_ptr_gray,
  output cdc_fifo_pkg::fifo_flag_t wr_flags
);
  import cdc_fifo_pkg::*;

  localparam logic [ADDR_WIDTH:0] AFULL_LVL = (ADDR_WIDTH+1)'(FIFO_AFULL);

  logic [ADDR_WIDTH:0] wr_ptr_bin;
  logic [ADDR_WIDTH:0] wr_ptr_next;
  logic [ADDR_WIDTH:0] rd_gray_s1;
  logic [ADDR_WIDTH:0] rd_gray_s2;
  logic [ADDR_WIDTH:0] rd_ptr_sync;   // Binary read pointer, write domain
  logic [ADDR_WIDTH:0] wr_used_next;
  fifo_flag_t          flags_next;

  assign we          = wr_en && !wr_flags.level;  // Ignored while full
  assign waddr       = wr_ptr_bin[ADDR_WIDTH-1:0];
  assign wr_ptr_next = wr_ptr_bin + {{ADDR_WIDTH{1'b0}}, we};

  // Gray copy is registered so only one bit moves toward the read side
  always_ff @(posedge wr_clk) begin
    if (!rst_n) begin
      wr_ptr_bin  <= '0;
      wr_ptr_gray <= '0;
    end else begin
      wr_ptr_bin  <= wr_ptr_next;
      wr_ptr_gray <= wr_ptr_next ^ (wr_ptr_next >> 1);
    end
  end

  always_ff @(posedge wr_clk) begin
    if (!rst_n) begin
      rd_gray_s1 <= '0;
      rd_gray_s2 <= '0;
    end else begin
      rd_gray_s1 <= rd_ptr_gray;  // First stage, may go metastable
      rd_gray_s2 <= rd_gray_s1;
    end
  end

  // Gray to binary
  always_comb begin
    for (int i = 0; i <= ADDR_WIDTH; i++) begin
      rd_ptr_sync[i] = ^(rd_gray_s2 >> i);
    end
  end

  // Stale read pointer only overstates the occupancy
  assign wr_used_next = wr_ptr_next - rd_ptr_sync;

  always_comb begin
    flags_next.level  = (wr_ptr_next == {~rd_ptr_sync[ADDR_WIDTH],
                                          rd_ptr_sync[ADDR_WIDTH-1:0]});
    flags_next.almost = (wr_used_next >= AFULL_LVL);
  end

  always_ff @(posedge wr_clk) begin
    if (!rst_n) begin
      wr_flags <= '{level: 1'b0, almost: 1'b0};
    end else begin
      wr_flags <= flags_next;
    end
  end

  // A write never lands on a slot the read side still owns
  a_no_overrun: assert property (@(posedge wr_clk) disable iff (!rst_n)
    we |-> ((wr_ptr_bin - rd_ptr_sync) < (ADDR_WIDTH+1)'(FIFO_DEPTH)))
    else $error("write accepted while the FIFO was full");

  a_wr_gray_step: assert property (@(posedge wr_clk) disable iff (!rst_n)
    $countones(wr_ptr_gray ^ $past(wr_ptr_gray)) <= 1)
    else $error("write Gray pointer changed more than one bit");

endmodule

//--- common/cdc_fifo_pkg.sv
package cdc_fifo_pkg;

  localparam int TAG_WIDTH     = 4;
  localparam int PAYLOAD_WIDTH = 12;

  // One transferred word
  typedef struct packed {
    logic [TAG_WIDTH-1:0]     tag;      // Channel tag
    logic [PAYLOAD_WIDTH-1:0] payload;
  } fifo_word_t;

  // Flags of one side
  typedef struct packed {
    logic level;   // Full or empty
    logic almost;  // Almost full or almost empty
  } fifo_flag_t;

  localparam int DEFAULT_DEPTH  = 16;
  localparam int DEFAULT_AFULL  = 15;  // Write side, occupancy at or above
  localparam int DEFAULT_AEMPTY = 1;   // Read side, occupancy at or below

endpackage

//--- design/cdc_fifo_top.sv
`timescale 1ns/1ps

module cdc_fifo_top #(
  parameter int FIFO_DEPTH  = cdc_fifo_pkg::DEFAULT_DEPTH,
  parameter int FIFO_AFULL  = cdc_fifo_pkg::DEFAULT_AFULL,
  parameter int FIFO_AEMPTY = cdc_fifo_pkg::DEFAULT_AEMPTY
) (
  // Write domain
  input  logic                     wr_clk,
  input  logic                     rst_n,
  input  logic                     wr_en,
  input  cdc_fifo_pkg::fifo_word_t wr_data,
  output cdc_fifo_pkg::fifo_flag_t wr_flags,
  // Read domain
  input  logic                     rd_clk,
  input  logic                     rd_en,
  output cdc_fifo_pkg::fifo_word_t rd_data,
  output logic                     rd_valid,
  output cdc_fifo_pkg::fifo_flag_t rd_flags
);

  async_fifo #(
    .FIFO_DEPTH  (FIFO_DEPTH),
    .FIFO_AFULL  (FIFO_AFULL),
    .FIFO_AEMPTY (FIFO_AEMPTY)
  ) i_fifo (
    .wr_clk   (wr_clk),
    .rst_n    (rst_n),
    .wr_en    (wr_en),
    .wr_data  (wr_data),
    .wr_flags (wr_flags),
    .rd_clk   (rd_clk),
    .rd_en    (rd_en),
    .rd_data  (rd_data),
    .rd_valid (rd_valid),
    .rd_flags (rd_flags)
  );

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build with Verilator, run the testbench, then search the log for the pass line

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing --assert -j 0 \
    --top-module tb_cdc_fifo -f sim.f \
  && ./obj_dir/Vtb_cdc_fifo 2>&1 | tee "$LOG" \
  || echo "Build or simulation step returned an error"

grep -qx "Finished with no errors" "$LOG" 2>/dev/null \
  && echo "Simulation passed" \
  || { echo "Simulation failed, see $LOG"; exit 1; }

exit 0

//--- sim.f
+incdir+verification
common/cdc_fifo_pkg.sv
async_fifo/fifo_dual_port_ram.sv
async_fifo/fifo_wr_ctrl.sv
async_fifo/fifo_rd_ctrl.sv
async_fifo/async_fifo.sv
design/cdc_fifo_top.sv
verification/tb_cdc_fifo.sv

//--- verification/tb_cdc_fifo_checks.svh
// Every failing check ends here
task automatic report_failure(input string msg);
  $display("%s", msg);
  $display("Finished with errors");
  $fatal(1, "stopped at the first error");
endtask

task automatic check_word(
  input string      name,
  input fifo_word_t got,
  input fifo_word_t exp
);
  if (got !== exp) begin
    report_failure($sformatf("FAILED %s: got 0x%04h, expected 0x%04h", name, got, exp));
  end
endtask

task automatic check_flag(
  input string name,
  input logic  got,
  input logic  exp
);
  if (got !== exp) begin
    report_failure($sformatf("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp));
  end
endtask

// Write side may only overstate the occupancy
task automatic verify_wr_flags(input int occ);
  if (occ == DEPTH) begin
    check_flag("wr_flags.level", wr_flags.level, 1'b1);
  end
  if (occ >= AFULL_LVL) begin
    check_flag("wr_flags.almost", wr_flags.almost, 1'b1);
  end
endtask

// Read side may only understate it
task automatic verify_rd_flags(input int occ);
  if (occ == 0) begin
    check_flag("rd_flags.level", rd_flags.level, 1'b1);
  end
  if (occ <= AEMPTY_LVL) begin
    check_flag("rd_flags.almost", rd_flags.almost, 1'b1);
  end
endtask

//--- verification/tb_cdc_fifo.sv
`timescale 1ns/1ps

module tb_cdc_fifo;
  import cdc_fifo_pkg::*;

  localparam int  DEPTH              = 16;
  localparam int  AFULL_LVL          = 12;
  localparam int  AEMPTY_LVL         = 2;
  localparam real WR_PERIOD          = 40.0;
  localparam real RD_PERIOD          = 58.0;
  localparam real RD_OFFSET          = 3.5;  // Keeps every rd_clk edge off the wr_clk edges
  localparam int  RESET_CYCLES       = 8;
  localparam int  SEED               = 55106;
  localparam int  WRITE_HEAVY_CYCLES = 300;
  localparam int  READ_HEAVY_CYCLES  = 300;
  localparam int  BALANCED_CYCLES    = 400;
  localparam int  DRAIN_CYCLES       = 200;
  localparam int  TOTAL_CYCLES       = RESET_CYCLES + WRITE_HEAVY_CYCLES + READ_HEAVY_CYCLES
                                       + BALANCED_CYCLES + DRAIN_CYCLES;
  localparam real WATCHDOG_NS        = 2.0 * TOTAL_CYCLES * RD_PERIOD;
  localparam int  RAND_LEN           = 2048;

  typedef enum logic [2:0] {
    PH_IDLE,
    PH_WRITE_HEAVY,
    PH_READ_HEAVY,
    PH_BALANCED,
    PH_DRAIN
  } phase_t;

  logic       wr_clk;
  logic       rd_clk;
  logic       rst_n;
  logic       wr_en;
  logic       rd_en;
  logic       rd_valid;
  fifo_word_t wr_data;
  fifo_word_t rd_data;
  fifo_flag_t wr_flags;
  fifo_flag_t rd_flags;

  phase_t     phase;
  logic       checking;

  // Reference model, words in write order
  fifo_word_t sent_q[$];
  int         rd_count;                  // Words committed by the read side

  int                       wr_roll[$];
  int                       rd_roll[$];
  logic [PAYLOAD_WIDTH-1:0] payload_q[$];

  `include "tb_cdc_fifo_checks.svh"

  cdc_fifo_top #(
    .FIFO_DEPTH  (DEPTH),
    .FIFO_AFULL  (AFULL_LVL),
    .FIFO_AEMPTY (AEMPTY_LVL)
  ) i_dut (
    .wr_clk   (wr_clk),
    .rst_n    (rst_n),
    .wr_en    (wr_en),
    .wr_data  (wr_data),
    .wr_flags (wr_flags),
    .rd_clk   (rd_clk),
    .rd_en    (rd_en),
    .rd_data  (rd_data),
    .rd_valid (rd_valid),
    .rd_flags (rd_flags)
  );

  initial begin : wr_clock
    wr_clk = 1'b0;
    forever #(WR_PERIOD / 2.0) wr_clk = ~wr_clk;
  end

  initial begin : rd_clock
    rd_clk = 1'b0;
    #(RD_OFFSET);
    forever #(RD_PERIOD / 2.0) rd_clk = ~rd_clk;
  end

  initial begin : main_sequence
    logic [31:0] rnd;
    int          seed;
    rst_n    = 1'b0;
    checking = 1'b0;
    phase    = PH_IDLE;
    seed     = SEED;
    for (int i = 0; i < RAND_LEN; i++) begin
      rnd = $random(seed);
      wr_roll.push_back(int'(rnd[15:0]) % 100);
      rnd = $random(seed);
      rd_roll.push_back(int'(rnd[15:0]) % 100);
      rnd = $random(seed);
      payload_q.push_back(rnd[PAYLOAD_WIDTH-1:0]);
    end
    repeat (RESET_CYCLES) @(negedge wr_clk);
    rst_n = 1'b1;
    repeat (4) @(negedge rd_clk);  // Read domain is out of reset after two edges
    check_flag("rd_flags.level", rd_flags.level, 1'b1);
    check_flag("rd_flags.almost", rd_flags.almost, 1'b1);
    check_flag("rd_valid", rd_valid, 1'b0);
    @(negedge wr_clk);
    check_flag("wr_flags.level", wr_flags.level, 1'b0);
    check_flag("wr_flags.almost", wr_flags.almost, 1'b0);
    @(posedge wr_clk);
    checking = 1'b1;
    phase    = PH_WRITE_HEAVY;
    repeat (WRITE_HEAVY_CYCLES) @(posedge wr_clk);
    phase = PH_READ_HEAVY;
    repeat (READ_HEAVY_CYCLES) @(posedge wr_clk);
    phase = PH_BALANCED;
    repeat (BALANCED_CYCLES) @(posedge wr_clk);
    phase = PH_DRAIN;
    @(negedge wr_clk);  // Last accepted write is in the model by now
    while (sent_q.size() != rd_count) begin
      @(negedge wr_clk);
    end
    repeat (4) @(negedge rd_clk);
    check_flag("rd_flags.level", rd_flags.level, 1'b1);
    if (rd_count > 0) begin
      $display("%0d words carried from wr_clk to rd_clk", rd_count);
      $display("Finished with no errors");
      $finish;
    end else begin
      report_failure("No word was carried through the FIFO");
    end
  end

  // Flags checked and inputs driven on the falling edge, model updated on the rising edge
  initial begin : write_side
    int                   occ;
    int                   wr_pct;
    int                   wr_cycle;
    logic                 need_word;
    logic                 accept;
    logic [TAG_WIDTH-1:0] tag;
    wr_en     = 1'b0;
    wr_data   = '0;
    wr_cycle  = 0;
    need_word = 1'b1;
    accept    = 1'b0;
    tag       = '0;
    forever begin
      @(negedge wr_clk);
      occ = sent_q.size() - rd_count;
      if (checking) begin
        verify_wr_flags(occ);
      end
      case (phase)
        PH_WRITE_HEAVY: wr_pct = 80;
        PH_READ_HEAVY:  wr_pct = 25;
        PH_BALANCED:    wr_pct = 55;
        default:        wr_pct = 0;
      endcase
      if (need_word) begin  // Otherwise the refused word is held
        wr_data.tag     = tag;
        wr_data.payload = payload_q[wr_cycle % RAND_LEN];
        tag             = tag + 4'd1;
      end
      wr_en    = (wr_roll[wr_cycle % RAND_LEN] < wr_pct);
      wr_cycle = wr_cycle + 1;
      accept   = wr_en && !wr_flags.level;
      @(posedge wr_clk);
      if (accept) begin
        sent_q.push_back(wr_data);
      end
      need_word = accept;
    end
  end

  initial begin : read_side
    int         occ;
    int         rd_pct;
    int         rd_cycle;
    logic       commit;
    logic       valid_expected;
    fifo_word_t exp_word;
    rd_en          = 1'b0;
    rd_count       = 0;
    rd_cycle       = 0;
    commit         = 1'b0;
    valid_expected = 1'b0;
    exp_word       = '0;
    forever begin
      @(negedge rd_clk);
      occ = sent_q.size() - rd_count;
      if (checking) begin
        check_flag("rd_valid", rd_valid, valid_expected);
        if (valid_expected) begin
          check_word("rd_data", rd_data, exp_word);
        end
        verify_rd_flags(occ);
      end
      case (phase)
        PH_WRITE_HEAVY: rd_pct = 35;
        PH_READ_HEAVY:  rd_pct = 90;
        PH_BALANCED:    rd_pct = 70;
        PH_DRAIN:       rd_pct = 75;
        default:        rd_pct = 0;
      endcase
      rd_en    = (rd_roll[rd_cycle % RAND_LEN] < rd_pct);
      rd_cycle = rd_cycle + 1;
      commit   = rd_en && !rd_flags.level;
      @(posedge rd_clk);
      valid_expected = commit;  // Data shows up one rd_clk later
      if (commit) begin
        if (rd_count >= sent_q.size()) begin
          report_failure("Underflow: read committed while the model held no word");
        end else begin
          exp_word = sent_q[rd_count];
          rd_count = rd_count + 1;
        end
      end
    end
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    report_failure($sformatf("Timeout: the test did not finish within %0.0f ns", WATCHDOG_NS));
  end

endmodule
